//--- files.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/path_pkg.sv
hdl/path_if.sv
hdl/path_fetch.sv
hdl/path_pipe.sv
hdl/branch_control.sv
hdl/eager_branch_unit.sv
tests/tb_eager_branch_unit.sv

//--- hdl/branch_control.sv
`timescale 1ns/100ps

module branch_control (
	input  logic               clk,
	input  logic               rst,
	path_if.resolver           t_path,
	path_if.resolver           n_path,
	output logic               flush_ifid_t,
	output logic               flush_idex_t,
	output logic               flush_ifid_n,
	output logic               flush_idex_n,
	output logic               correct_en_t,
	output logic               correct_en_n,
	output isa_pkg::pc_t       correction_t,
	output isa_pkg::pc_t       correction_n,
	output path_pkg::primary_t primary
);

	logic ex_branch_t;
	logic ex_branch_n;
	logic ex_taken_t;
	logic ex_taken_n;
	logic id_branch_t;
	logic id_branch_n;
	logic back_to_back;
	logic taken;

	assign ex_branch_t = t_path.branch1 | t_path.branch2;
	assign ex_branch_n = n_path.branch1 | n_path.branch2;
	assign ex_taken_t  = ex_branch_t & (t_path.taken1 | t_path.taken2);
	assign ex_taken_n  = ex_branch_n & (n_path.taken1 | n_path.taken2);
	assign id_branch_t = t_path.branch1_id | t_path.branch2_id;
	assign id_branch_n = n_path.branch1_id | n_path.branch2_id;
	assign taken       = ex_taken_t | ex_taken_n;

	// a branch in EX with another one right behind it in ID, and the two
	// paths have already split in decode
	assign back_to_back = ((ex_branch_t & id_branch_t) | (ex_branch_n & id_branch_n)) &
	                      (t_path.next_pc_id != n_path.next_pc_id);

	always_comb begin
		correct_en_t = 1'b0;
		correct_en_n = 1'b0;
		correction_t = '0;
		correction_n = '0;

		if (back_to_back) begin
			if (taken) begin
				// n falls through past the decode branch
				correct_en_n = 1'b1;
				correction_n = t_path.next_pc_id;
			end else begin
				// t jumps to the target of the decode branch
				correct_en_t = 1'b1;
				correction_t = n_path.bta_id;
			end
		end else if (ex_branch_t | ex_branch_n) begin
			if (taken) begin
				correct_en_n = 1'b1;
				correction_n = t_path.next_pc_ex;
			end else begin
				correct_en_t = 1'b1;
				correction_t = n_path.next_pc_ex;
			end
		end
	end

	// the redirected path loses both of its younger stages
	assign flush_ifid_t = correct_en_t;
	assign flush_idex_t = correct_en_t;
	assign flush_ifid_n = correct_en_n;
	assign flush_idex_n = correct_en_n;

	// only a branch in the primary pipe moves the primary state
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			primary <= path_pkg::PRIMARY_T;
		end else begin
			case (primary)
				path_pkg::PRIMARY_T: begin
					if (ex_branch_t) begin
						primary <= ex_taken_t ? path_pkg::PRIMARY_T : path_pkg::PRIMARY_N;
					end
				end
				path_pkg::PRIMARY_N: begin
					if (ex_branch_n) begin
						primary <= ex_taken_n ? path_pkg::PRIMARY_T : path_pkg::PRIMARY_N;
					end
				end
				default: primary <= path_pkg::PRIMARY_T;
			endcase
		end
	end

endmodule

//--- hdl/eager_branch_unit.sv
`timescale 1ns/100ps
`include "eager_defines.svh"

module eager_branch_unit (
	input  logic               clk,
	input  logic               rst,
	input  isa_pkg::word_t     word_t,
	input  isa_pkg::word_t     word_n,
	input  isa_pkg::flags_t    flags,
	output isa_pkg::pc_t       fetch_pc_t,
	output isa_pkg::pc_t       fetch_pc_n,
	output logic               correct_en_t,
	output logic               correct_en_n,
	output isa_pkg::pc_t       correction_t,
	output isa_pkg::pc_t       correction_n,
	output path_pkg::primary_t primary
);

	localparam path_pkg::path_idx_t T_IDX = 1'b0;
	localparam path_pkg::path_idx_t N_IDX = 1'b1;

	path_if stat [`N_PATHS] ();

	isa_pkg::pc_t   path_pc         [`N_PATHS];
	isa_pkg::word_t path_word       [`N_PATHS];
	logic           path_flush_ifid [`N_PATHS];
	logic           path_flush_idex [`N_PATHS];

	assign path_pc[T_IDX]   = fetch_pc_t;
	assign path_pc[N_IDX]   = fetch_pc_n;
	assign path_word[T_IDX] = word_t;
	assign path_word[N_IDX] = word_n;

	path_fetch u_fetch (
		.clk          (clk),
		.rst          (rst),
		.correct_en_t (correct_en_t),
		.correct_en_n (correct_en_n),
		.correction_t (correction_t),
		.correction_n (correction_n),
		.fetch_pc_t   (fetch_pc_t),
		.fetch_pc_n   (fetch_pc_n)
	);

	for (genvar i = 0; i < `N_PATHS; i++) begin : g_path
		path_pipe u_pipe (
			.clk        (clk),
			.rst        (rst),
			.fetch_pc   (path_pc[i]),
			.word       (path_word[i]),
			.flags      (flags),
			.flush_ifid (path_flush_ifid[i]),
			.flush_idex (path_flush_idex[i]),
			.stat       (stat[i])
		);
	end

	branch_control u_resolver (
		.clk          (clk),
		.rst          (rst),
		.t_path       (stat[T_IDX]),
		.n_path       (stat[N_IDX]),
		.flush_ifid_t (path_flush_ifid[T_IDX]),
		.flush_idex_t (path_flush_idex[T_IDX]),
		.flush_ifid_n (path_flush_ifid[N_IDX]),
		.flush_idex_n (path_flush_idex[N_IDX]),
		.correct_en_t (correct_en_t),
		.correct_en_n (correct_en_n),
		.correction_t (correction_t),
		.correction_n (correction_n),
		.primary      (primary)
	);

endmodule

//--- hdl/eager_defines.svh
`ifndef EAGER_DEFINES_SVH
`define EAGER_DEFINES_SVH

// word address width
`define PC_W 10

// one instruction slot and the two-slot fetch word
`define SLOT_W 16
`define N_SLOTS 2
`define WORD_W (`SLOT_W * `N_SLOTS)

// path 0 is the taken path, path 1 the not-taken path
`define N_PATHS 2

// both paths start fetching here
`define RESET_PC 10'd0

`define FLAG_W 4

// opcode value of a conditional branch
`define OP_BRANCH 4'hB

`endif

//--- hdl/isa_pkg.sv
`include "eager_defines.svh"

package isa_pkg;

	// word address into instruction memory
	typedef logic [`PC_W-1:0] pc_t;

	// one instruction and one fetch word
	typedef logic [`SLOT_W-1:0] slot_t;
	typedef logic [`WORD_W-1:0] word_t;

	// slot bits 15:12
	typedef logic [3:0] opcode_t;

	// slot bits 11:10, picks one of the flags
	typedef logic [1:0] cond_t;

	// slot bits 7:0, signed word offset from the branch word
	typedef logic signed [7:0] offset_t;

	// external condition flags
	typedef logic [`FLAG_W-1:0] flags_t;

endpackage

//--- hdl/path_fetch.sv
`timescale 1ns/100ps
`include "eager_defines.svh"

module path_fetch (
	input  logic         clk,
	input  logic         rst,
	input  logic         correct_en_t,
	input  logic         correct_en_n,
	input  isa_pkg::pc_t correction_t,
	input  isa_pkg::pc_t correction_n,
	output isa_pkg::pc_t fetch_pc_t,
	output isa_pkg::pc_t fetch_pc_n
);

	isa_pkg::pc_t next_pc_t;
	isa_pkg::pc_t next_pc_n;

	// a correction from the resolver wins over the sequential step
	always_comb begin
		if (correct_en_t) begin
			next_pc_t = correction_t;
		end else begin
			next_pc_t = fetch_pc_t + isa_pkg::pc_t'(1);
		end

		if (correct_en_n) begin
			next_pc_n = correction_n;
		end else begin
			next_pc_n = fetch_pc_n + isa_pkg::pc_t'(1);
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fetch_pc_t <= `RESET_PC;
			fetch_pc_n <= `RESET_PC;
		end else begin
			fetch_pc_t <= next_pc_t;
			fetch_pc_n <= next_pc_n;
		end
	end

endmodule

//--- hdl/path_if.sv
`timescale 1ns/100ps

interface path_if;

	// branch slots in EX and their outcomes
	logic branch1;
	logic branch2;
	logic taken1;
	logic taken2;

	// branch slots in ID
	logic branch1_id;
	logic branch2_id;

	// target of the first branch slot in ID
	isa_pkg::pc_t bta_id;

	// fall-through addresses of the EX and ID words
	isa_pkg::pc_t next_pc_ex;
	isa_pkg::pc_t next_pc_id;

	modport pipe (
		output branch1, branch2, taken1, taken2,
		output branch1_id, branch2_id, bta_id,
		output next_pc_ex, next_pc_id
	);

	modport resolver (
		input branch1, branch2, taken1, taken2,
		input branch1_id, branch2_id, bta_id,
		input next_pc_ex, next_pc_id
	);

endinterface

//--- hdl/path_pipe.sv
`timescale 1ns/100ps
`include "eager_defines.svh"

module path_pipe (
	input  logic            clk,
	input  logic            rst,
	input  isa_pkg::pc_t    fetch_pc,
	input  isa_pkg::word_t  word,
	input  isa_pkg::flags_t flags,
	input  logic            flush_ifid,
	input  logic            flush_idex,
	path_if.pipe            stat
);

	// slot decode helpers, slot 1 sits in the upper half of the word
	function automatic logic is_branch(isa_pkg::slot_t s);
		isa_pkg::opcode_t op;
		op = s[15:12];
		return op == `OP_BRANCH;
	endfunction

	function automatic isa_pkg::pc_t branch_target(isa_pkg::pc_t pc, isa_pkg::slot_t s);
		isa_pkg::offset_t off;
		off = s[7:0];
		return pc + {{(`PC_W-8){off[7]}}, off};
	endfunction

	function automatic logic cond_met(isa_pkg::slot_t s, isa_pkg::flags_t f);
		isa_pkg::cond_t c;
		c = s[11:10];
		return f[c];
	endfunction

	isa_pkg::pc_t   ifid_pc;
	isa_pkg::word_t ifid_word;
	isa_pkg::pc_t   idex_pc;
	isa_pkg::word_t idex_word;

	isa_pkg::slot_t id_slot1;
	isa_pkg::slot_t id_slot2;
	isa_pkg::slot_t ex_slot1;
	isa_pkg::slot_t ex_slot2;

	// an all-zero word decodes as two ordinary slots, so flush writes zero
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ifid_word <= '0;
			idex_word <= '0;
		end else begin
			ifid_word <= flush_ifid ? '0 : word;
			idex_word <= flush_idex ? '0 : ifid_word;
		end
	end

	always_ff @(posedge clk) begin
		ifid_pc <= fetch_pc;
		idex_pc <= ifid_pc;
	end

	assign id_slot1 = ifid_word[`WORD_W-1:`SLOT_W];
	assign id_slot2 = ifid_word[`SLOT_W-1:0];
	assign ex_slot1 = idex_word[`WORD_W-1:`SLOT_W];
	assign ex_slot2 = idex_word[`SLOT_W-1:0];

	// ID stage
	assign stat.branch1_id = is_branch(id_slot1);
	assign stat.branch2_id = is_branch(id_slot2);
	assign stat.bta_id     = stat.branch1_id ? branch_target(ifid_pc, id_slot1)
	                                         : branch_target(ifid_pc, id_slot2);
	assign stat.next_pc_id = ifid_pc + isa_pkg::pc_t'(1);

	// EX stage, flags are sampled here
	assign stat.branch1    = is_branch(ex_slot1);
	assign stat.branch2    = is_branch(ex_slot2);
	assign stat.taken1     = stat.branch1 & cond_met(ex_slot1, flags);
	assign stat.taken2     = stat.branch2 & cond_met(ex_slot2, flags);
	assign stat.next_pc_ex = idex_pc + isa_pkg::pc_t'(1);

endmodule

//--- hdl/path_pkg.sv
package path_pkg;

	// which pipe currently holds the architectural path
	typedef enum logic {
		PRIMARY_T = 1'b1,
		PRIMARY_N = 1'b0
	} primary_t;

	// index into the per-path arrays, 0 is t and 1 is n
	typedef logic path_idx_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# builds the eager branch unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_eager_branch_unit

verilator --binary --timing --timescale 1ns/100ps -f files.f \
	--top-module "$TOP" --Mdir "$OBJ" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$OBJ/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	exit 1
fi
exit 0

//--- tests/tb_eager_branch_unit.sv
`timescale 1ns/100ps

module tb_eager_branch_unit;

	localparam int N_STEPS = 31;
	localparam path_pkg::primary_t P_T = path_pkg::PRIMARY_T;
	localparam path_pkg::primary_t P_N = path_pkg::PRIMARY_N;

	logic               clk;
	logic               rst;
	isa_pkg::word_t     t_word;
	isa_pkg::word_t     n_word;
	isa_pkg::flags_t    flags;
	isa_pkg::pc_t       fetch_pc_t;
	isa_pkg::pc_t       fetch_pc_n;
	logic               correct_en_t;
	logic               correct_en_n;
	isa_pkg::pc_t       correction_t;
	isa_pkg::pc_t       correction_n;
	path_pkg::primary_t primary;

	// instruction memories of the two paths
	isa_pkg::word_t imem_t [64];
	isa_pkg::word_t imem_n [64];

	// step table with one entry per cycle after reset
	isa_pkg::flags_t    step_flags [N_STEPS];
	logic               exp_en_t   [N_STEPS];
	logic               exp_en_n   [N_STEPS];
	isa_pkg::pc_t       exp_corr_t [N_STEPS];
	isa_pkg::pc_t       exp_corr_n [N_STEPS];
	isa_pkg::pc_t       exp_pc_t   [N_STEPS];
	isa_pkg::pc_t       exp_pc_n   [N_STEPS];
	path_pkg::primary_t exp_pri    [N_STEPS];

	int n_rows;
	int row;
	int row_errors;
	int n_checks;
	int n_errors;

	eager_branch_unit dut0 (
		.clk          (clk),
		.rst          (rst),
		.word_t       (t_word),
		.word_n       (n_word),
		.flags        (flags),
		.fetch_pc_t   (fetch_pc_t),
		.fetch_pc_n   (fetch_pc_n),
		.correct_en_t (correct_en_t),
		.correct_en_n (correct_en_n),
		.correction_t (correction_t),
		.correction_n (correction_n),
		.primary      (primary)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ordinary slots carry the address, so every word differs
	function automatic isa_pkg::word_t filler(isa_pkg::pc_t a);
		return {4'h1, 2'b00, a, 4'h2, 2'b00, a};
	endfunction

	function automatic isa_pkg::slot_t enc_branch(isa_pkg::cond_t c, isa_pkg::offset_t off);
		return {4'hB, c, 2'b00, off};
	endfunction

	task automatic add_step(input isa_pkg::flags_t f, input logic en_t, input logic en_n,
			input isa_pkg::pc_t c_t, input isa_pkg::pc_t c_n,
			input isa_pkg::pc_t p_t, input isa_pkg::pc_t p_n,
			input path_pkg::primary_t pri);
		step_flags[n_rows] = f;
		exp_en_t[n_rows] = en_t;
		exp_en_n[n_rows] = en_n;
		exp_corr_t[n_rows] = c_t;
		exp_corr_n[n_rows] = c_n;
		exp_pc_t[n_rows] = p_t;
		exp_pc_n[n_rows] = p_n;
		exp_pri[n_rows] = pri;
		n_rows++;
	endtask

	task automatic check_pc(input string name, input isa_pkg::pc_t got, input isa_pkg::pc_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			row_errors++;
			$display("** Error: step %0d %s = 0x%h, expected 0x%h", row, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			row_errors++;
			$display("** Error: step %0d %s = 0x%h, expected 0x%h", row, name, got, exp);
		end
	endtask

	task automatic check_primary(input string name, input path_pkg::primary_t got,
			input path_pkg::primary_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			row_errors++;
			$display("** Error: step %0d %s = 0x%h, expected 0x%h", row, name, got, exp);
		end
	endtask

	task automatic load_memories();
		for (int a = 0; a < 64; a++) begin
			imem_t[a] = filler(isa_pkg::pc_t'(a));
			imem_n[a] = filler(isa_pkg::pc_t'(a));
		end
		imem_t[3][31:16]  = enc_branch(2'd0, 8'h06);
		imem_n[7][31:16]  = enc_branch(2'd3, 8'h10);
		// back-to-back pair with the second one in slot 2
		imem_t[14][31:16] = enc_branch(2'd1, 8'hF0);
		imem_t[15][15:0]  = enc_branch(2'd0, 8'h04);
		// fetched on the wrong path as t 14 resolves and dropped from IF/ID
		imem_t[16][31:16] = enc_branch(2'd3, 8'h02);
		imem_n[24][15:0]  = enc_branch(2'd2, 8'h08);
	endtask

	task automatic load_steps();
		// flags, correct_en_t/n, correction_t/n, fetch_pc_t/n, primary
		add_step(4'h0, 1'b0, 1'b0, 10'd0,  10'd0,  10'd0,  10'd0,  P_T);
		add_step(4'h3, 1'b0, 1'b0, 10'd0,  10'd0,  10'd1,  10'd1,  P_T);
		add_step(4'h8, 1'b0, 1'b0, 10'd0,  10'd0,  10'd2,  10'd2,  P_T);
		add_step(4'hF, 1'b0, 1'b0, 10'd0,  10'd0,  10'd3,  10'd3,  P_T);
		add_step(4'h2, 1'b0, 1'b0, 10'd0,  10'd0,  10'd4,  10'd4,  P_T);
		// taken branch at t 3 sends n back to 4
		add_step(4'h1, 1'b0, 1'b1, 10'd0,  10'd4,  10'd5,  10'd5,  P_T);
		add_step(4'h0, 1'b0, 1'b0, 10'd0,  10'd0,  10'd6,  10'd4,  P_T);
		add_step(4'h9, 1'b0, 1'b0, 10'd0,  10'd0,  10'd7,  10'd5,  P_T);
		add_step(4'h5, 1'b0, 1'b0, 10'd0,  10'd0,  10'd8,  10'd6,  P_T);
		add_step(4'hC, 1'b0, 1'b0, 10'd0,  10'd0,  10'd9,  10'd7,  P_T);
		add_step(4'h7, 1'b0, 1'b0, 10'd0,  10'd0,  10'd10, 10'd8,  P_T);
		// not-taken branch at n 7 in the secondary pipe
		add_step(4'h6, 1'b1, 1'b0, 10'd8,  10'd0,  10'd11, 10'd9,  P_T);
		add_step(4'h1, 1'b0, 1'b0, 10'd0,  10'd0,  10'd8,  10'd10, P_T);
		add_step(4'hA, 1'b0, 1'b0, 10'd0,  10'd0,  10'd9,  10'd11, P_T);
		add_step(4'h3, 1'b0, 1'b0, 10'd0,  10'd0,  10'd10, 10'd12, P_T);
		add_step(4'hE, 1'b0, 1'b0, 10'd0,  10'd0,  10'd11, 10'd13, P_T);
		add_step(4'h0, 1'b0, 1'b0, 10'd0,  10'd0,  10'd12, 10'd14, P_T);
		add_step(4'hB, 1'b0, 1'b0, 10'd0,  10'd0,  10'd13, 10'd15, P_T);
		add_step(4'h4, 1'b0, 1'b0, 10'd0,  10'd0,  10'd14, 10'd16, P_T);
		add_step(4'hF, 1'b0, 1'b0, 10'd0,  10'd0,  10'd15, 10'd17, P_T);
		// t 14 in EX and t 15 in ID send t to n's decode target 17 + 17
		add_step(4'hD, 1'b1, 1'b0, 10'd34, 10'd0,  10'd16, 10'd18, P_T);
		add_step(4'h2, 1'b0, 1'b0, 10'd0,  10'd0,  10'd34, 10'd19, P_N);
		add_step(4'h8, 1'b0, 1'b0, 10'd0,  10'd0,  10'd35, 10'd20, P_N);
		add_step(4'h6, 1'b0, 1'b0, 10'd0,  10'd0,  10'd36, 10'd21, P_N);
		add_step(4'h1, 1'b0, 1'b0, 10'd0,  10'd0,  10'd37, 10'd22, P_N);
		add_step(4'h9, 1'b0, 1'b0, 10'd0,  10'd0,  10'd38, 10'd23, P_N);
		add_step(4'hF, 1'b0, 1'b0, 10'd0,  10'd0,  10'd39, 10'd24, P_N);
		add_step(4'h3, 1'b0, 1'b0, 10'd0,  10'd0,  10'd40, 10'd25, P_N);
		// taken branch in the primary n pipe
		add_step(4'h4, 1'b0, 1'b1, 10'd0,  10'd40, 10'd41, 10'd26, P_N);
		add_step(4'h0, 1'b0, 1'b0, 10'd0,  10'd0,  10'd42, 10'd40, P_T);
		add_step(4'h7, 1'b0, 1'b0, 10'd0,  10'd0,  10'd43, 10'd41, P_T);
	endtask

	initial begin
		rst = 1'b0;
		flags = '0;
		n_rows = 0;
		n_checks = 0;
		n_errors = 0;
		load_memories();
		load_steps();
		t_word = imem_t[0];
		n_word = imem_n[0];
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b1;
		for (row = 0; row < n_rows; row++) begin
			row_errors = 0;
			flags = step_flags[row];
			t_word = imem_t[fetch_pc_t[5:0]];
			n_word = imem_n[fetch_pc_n[5:0]];
			#5;
			check_bit("correct_en_t", correct_en_t, exp_en_t[row]);
			check_bit("correct_en_n", correct_en_n, exp_en_n[row]);
			check_pc("correction_t", correction_t, exp_corr_t[row]);
			check_pc("correction_n", correction_n, exp_corr_n[row]);
			check_pc("fetch_pc_t", fetch_pc_t, exp_pc_t[row]);
			check_pc("fetch_pc_n", fetch_pc_n, exp_pc_n[row]);
			check_primary("primary", primary, exp_pri[row]);
			if (row_errors == 0) begin
				$display("step %0d: ok", row);
			end else begin
				$display("step %0d: %0d mismatches", row, row_errors);
			end
			@(posedge clk);
			#1;
		end
		$display("steps: %0d, checks: %0d, errors: %0d", n_rows, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// watchdog with a margin of ten cycles over the step table
	initial begin
		#((N_STEPS + 10) * 10);
		$display("timeout: the steps did not finish within %0d ns", (N_STEPS + 10) * 10);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule
